//--- tb.f
+incdir+.
bypassPkg.sv
destDecode.sv
destPipe.sv
bypassSelect.sv
bypassSpec.sv
bypassSpecTb.sv

//--- Makefile
# Verilator build and run of the bypass control testbench
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = bypassSpecTb
FILELIST = tb.f
OBJDIR   = obj_dir

.PHONY: sim clean

# Passes only when the pass message shows up in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)

//--- bypassSpecTb.sv
// Testbench with clock, reset, directed and random stimulus, reference model and checker
`timescale 1ns/1ps
`include "bypass_defs.svh"

module bypassSpecTb;

  import bypassPkg::*;

  localparam bypassSel_t noneOnly = bypassSel_t'(1) << `SEL_NONE;

  // Flag bits for setCtl
  localparam int fLoad  = 1;
  localparam int fAKill = 2;
  localparam int fBKill = 4;
  localparam int fAIgn  = 8;
  localparam int fBIgn  = 16;
  localparam int fExc   = 32;

  logic       phi1 = 1'b0;
  logic       rst;
  logic       stall;
  regSpec_t   aRsSpec, aRtSpec, aRdSpec, bRtSpec, bRdSpec;
  logic       aDestIsRd, aDestIsRt, aDestIsLink, bDestIsRd, bDestIsRt, bIsLoad;
  logic       aKill, bKill, aIgnore, bIgnore, except;
  bypassSel_t sBypassSel, tBypassSel;
  logic       sBypassLoad, tBypassLoad, aMemLatchEn, bMemLatchEn;
  regSpec_t   aWbSpec, bWbSpec;
  logic       aWbValid, bWbValid, bWbLoad;

  // Model of the RF-to-EX specifiers, MEM and WB contents and the selects
  regSpec_t   mARt, mARd, mBRt, mBRd, mAMemD, mBMemD, mAWbD, mBWbD;
  logic       mAMemV, mBMemV, mBMemL, mAWbV, mBWbV, mBWbL;
  bypassSel_t mSSel, mTSel;

  int         errCount = 0;
  int         checkCount = 0;
  int         testCount = 0;
  int         testErr0 = 0;
  int         loadHits = 0;
  logic       checkOn = 1'b0;
  string      curTest = "reset";

  bypassSpec i_bypassSpec (.*);

  // 40 ns period
  always #20 phi1 = ~phi1;

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  function automatic regSpec_t destOf(input logic isRd, input logic isRt, input logic isLink,
                                      input regSpec_t rt, input regSpec_t rd);
    if (isRd) return rd;
    if (isRt) return rt;
    if (isLink) return regSpec_t'(`LINK_REG);
    return '0;
  endfunction

  // Needs a destination, no kill, not r0, no exception
  function automatic logic validOf(input regSpec_t dest, input logic hasDest,
                                   input logic kill, input logic exc);
    return hasDest && !kill && (dest != '0) && !exc;
  endfunction

  // Newest producer first, B ahead of A
  function automatic bypassSel_t expectSel(input regSpec_t src,
      input regSpec_t aExD, input logic aExV, input regSpec_t bExD, input logic bExV,
      input regSpec_t aMemD, input logic aMemV, input regSpec_t bMemD, input logic bMemV);
    if (bExV && src == bExD) return bypassSel_t'(1) << `SEL_BEX;
    if (aExV && src == aExD) return bypassSel_t'(1) << `SEL_AEX;
    if (bMemV && src == bMemD) return bypassSel_t'(1) << `SEL_BMEM;
    if (aMemV && src == aMemD) return bypassSel_t'(1) << `SEL_AMEM;
    return noneOnly;
  endfunction

  function automatic logic loadOf(input bypassSel_t sel);
    return sel[`SEL_BMEM] && mBWbL && mBWbV && !aKill;
  endfunction

  always @(posedge phi1) begin : model
    regSpec_t aExD;
    regSpec_t bExD;
    logic     aExV;
    logic     bExV;
    aExD = destOf(aDestIsRd, aDestIsRt, aDestIsLink, mARt, mARd);
    aExV = validOf(aExD, aDestIsRd || aDestIsRt || aDestIsLink, aKill, except);
    bExD = destOf(bDestIsRd, bDestIsRt, 1'b0, mBRt, mBRd);
    bExV = validOf(bExD, bDestIsRd || bDestIsRt, bKill, except);
    if (rst) begin
      {mARt, mARd, mBRt, mBRd, mAMemD, mBMemD, mAWbD, mBWbD} <= '0;
      {mAMemV, mBMemV, mBMemL, mAWbV, mBWbV, mBWbL} <= '0;
      mSSel <= noneOnly;
      mTSel <= noneOnly;
    end else if (!stall) begin
      mSSel  <= expectSel(aRsSpec, aExD, aExV, bExD, bExV, mAMemD, mAMemV, mBMemD, mBMemV);
      mTSel  <= expectSel(aRtSpec, aExD, aExV, bExD, bExV, mAMemD, mAMemV, mBMemD, mBMemV);
      // Ignore clears EX to MEM, exception clears MEM to WB
      mAMemD <= aExD;
      mAMemV <= aExV && !aIgnore;
      mBMemD <= bExD;
      mBMemV <= bExV && !bIgnore;
      mBMemL <= bIsLoad;
      mAWbD  <= mAMemD;
      mAWbV  <= mAMemV && !except;
      mBWbD  <= mBMemD;
      mBWbV  <= mBMemV && !except;
      mBWbL  <= mBMemL;
      {mARt, mARd, mBRt, mBRd} <= {aRtSpec, aRdSpec, bRtSpec, bRdSpec};
    end
  end

  // ---------------------------------------------------------------------------
  // Checker samples 5 ns before the rising edge
  // ---------------------------------------------------------------------------
  task automatic checkField(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    checkCount++;
    if (actVal !== expVal) begin
      errCount++;
      $display("FAILED %s %s expected %0h actual %0h at %0t",
               curTest, name, expVal, actVal, $time);
    end
  endtask

  always @(negedge phi1) begin
    #15;
    if (checkOn) begin
      checkField("sBypassSel", 32'(mSSel), 32'(sBypassSel));
      checkField("tBypassSel", 32'(mTSel), 32'(tBypassSel));
      checkField("sBypassLoad", 32'(loadOf(mSSel)), 32'(sBypassLoad));
      checkField("tBypassLoad", 32'(loadOf(mTSel)), 32'(tBypassLoad));
      checkField("aMemLatchEn", 32'(mAMemV && !stall), 32'(aMemLatchEn));
      checkField("bMemLatchEn", 32'(mBMemV && !stall), 32'(bMemLatchEn));
      checkField("aWbSpec", 32'(mAWbD), 32'(aWbSpec));
      checkField("aWbValid", 32'(mAWbV), 32'(aWbValid));
      checkField("bWbSpec", 32'(mBWbD), 32'(bWbSpec));
      checkField("bWbValid", 32'(mBWbV), 32'(bWbValid));
      checkField("bWbLoad", 32'(mBWbL), 32'(bWbLoad));
      if (sBypassLoad || tBypassLoad) loadHits++;
    end
  end

  // ---------------------------------------------------------------------------
  // Stimulus helpers change all inputs on the falling edge
  // ---------------------------------------------------------------------------
  task automatic tick(input int n);
    for (int i = 0; i < n; i++) @(negedge phi1);
  endtask

  // Next pair from RF
  task automatic setPair(input int aRs, input int aRt, input int aRd, input int bRt,
                         input int bRd);
    aRsSpec = regSpec_t'(aRs);
    aRtSpec = regSpec_t'(aRt);
    aRdSpec = regSpec_t'(aRd);
    bRtSpec = regSpec_t'(bRt);
    bRdSpec = regSpec_t'(bRd);
  endtask

  // EX control kinds are 0 none, 1 RD, 2 RT and 3 link
  task automatic setCtl(input int aKind, input int bKind, input int flags);
    aDestIsRd   = (aKind == 1);
    aDestIsRt   = (aKind == 2);
    aDestIsLink = (aKind == 3);
    bDestIsRd   = (bKind == 1);
    bDestIsRt   = (bKind == 2);
    {except, bIgnore, aIgnore, bKill, aKill, bIsLoad} = flags[5:0];
  endtask

  // Specifiers 0 to 3 so that matches are frequent
  task automatic randomCycle(input int stallPct);
    setPair($urandom % 4, $urandom % 4, $urandom % 4, $urandom % 4, $urandom % 4);
    setCtl($urandom % 4, $urandom % 3, ($urandom & $urandom & $urandom) | ($urandom & fLoad));
    stall = ($urandom % 100) < stallPct;
  endtask

  task automatic startTest(input string name);
    curTest  = name;
    testErr0 = errCount;
  endtask

  task automatic finishTest();
    testCount++;
    $display("test %-14s %s, %0d errors", curTest,
             (errCount == testErr0) ? "ok" : "mismatch", errCount - testErr0);
  endtask

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial begin : stimulus
    int guard;
    int hits0;
    void'($urandom(32'h72265894));
    rst   = 1'b1;
    stall = 1'b0;
    setPair(0, 0, 0, 0, 0);
    setCtl(0, 0, 0);
    tick(8);
    rst = 1'b0;

    startTest("reset");
    guard = 0;
    while (sBypassSel !== noneOnly && guard < 16) begin
      @(negedge phi1);
      guard++;
    end
    if (guard == 16) begin
      errCount++;
      $display("S select never returned to SEL_NONE after reset");
    end
    checkOn = 1'b1;
    tick(3);
    finishTest();

    // A RD, B RT, then A link, B RD
    startTest("destChoice");
    setPair(0, 6, 5, 7, 9);
    tick(1);
    setPair(0, 2, 1, 4, 3);
    setCtl(1, 2, 0);
    tick(1);
    setPair(0, 0, 0, 0, 0);
    setCtl(3, 1, 0);
    tick(1);
    setCtl(0, 0, 0);
    tick(4);
    finishTest();

    startTest("validSuppress");
    setPair(0, 3, 4, 5, 6);
    tick(1);
    setPair(0, 3, 0, 5, 0);
    setCtl(1, 1, fAKill);
    tick(1);
    // r0 destinations on both sides
    setPair(0, 3, 4, 5, 6);
    setCtl(1, 1, 0);
    tick(1);
    setCtl(1, 1, fAIgn);
    tick(1);
    // Exception clears this EX pair and the pair now in MEM
    setCtl(1, 2, fExc);
    tick(1);
    setCtl(0, 0, fBIgn);
    tick(1);
    setCtl(0, 0, 0);
    tick(3);
    finishTest();

    startTest("bypassPriority");
    setPair(0, 3, 3, 3, 3);
    tick(1);
    setPair(3, 3, 0, 0, 0);
    setCtl(1, 1, 0);
    tick(1);
    setPair(3, 0, 0, 0, 0);
    setCtl(0, 0, 0);
    tick(3);
    repeat (300) begin
      randomCycle(0);
      tick(1);
    end
    finishTest();

    // Load, killed load use, non-load
    startTest("loadBypass");
    // Drain the random pairs before counting
    setPair(0, 0, 0, 0, 0);
    setCtl(0, 0, 0);
    tick(3);
    hits0 = loadHits;
    for (int v = 0; v < 3; v++) begin
      setPair(0, 0, 0, 0, 4);
      setCtl(0, 0, 0);
      tick(1);
      setPair(0, 0, 0, 0, 0);
      setCtl(0, 1, (v != 2) ? fLoad : 0);
      tick(1);
      setPair(4, 4, 0, 0, 0);
      setCtl(0, 0, 0);
      tick(1);
      setPair(0, 0, 0, 0, 0);
      setCtl(0, 0, (v == 1) ? fAKill : 0);
      tick(1);
    end
    if (loadHits - hits0 != 1) begin
      errCount++;
      $display("Load bypass was raised %0d times instead of once", loadHits - hits0);
    end
    finishTest();

    startTest("stall");
    repeat (120) begin
      randomCycle(35);
      tick(1);
    end
    repeat (20) begin
      randomCycle(0);
      tick(1);
    end
    finishTest();

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Run limit far above the normal length of about 20 us
  initial begin : watchdog
    #200000;
    $display("Run did not finish within the time limit");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- bypassSpec.sv
// Top of the dual-issue bypass control with two decoders, two pipes and two selectors
`timescale 1ns/1ps

module bypassSpec (
  input  logic                  phi1,
  input  logic                  rst,
  input  logic                  stall,
  input  bypassPkg::regSpec_t   aRsSpec,
  input  bypassPkg::regSpec_t   aRtSpec,
  input  bypassPkg::regSpec_t   aRdSpec,
  input  bypassPkg::regSpec_t   bRtSpec,
  input  bypassPkg::regSpec_t   bRdSpec,
  input  logic                  aDestIsRd,
  input  logic                  aDestIsRt,
  input  logic                  aDestIsLink,
  input  logic                  bDestIsRd,
  input  logic                  bDestIsRt,
  input  logic                  bIsLoad,
  input  logic                  aKill,
  input  logic                  bKill,
  input  logic                  aIgnore,
  input  logic                  bIgnore,
  input  logic                  except,
  output bypassPkg::bypassSel_t sBypassSel,
  output bypassPkg::bypassSel_t tBypassSel,
  output logic                  sBypassLoad,
  output logic                  tBypassLoad,
  output logic                  aMemLatchEn,
  output logic                  bMemLatchEn,
  output bypassPkg::regSpec_t   aWbSpec,
  output logic                  aWbValid,
  output bypassPkg::regSpec_t   bWbSpec,
  output logic                  bWbValid,
  output logic                  bWbLoad
);

  import bypassPkg::*;

  // EX and MEM destinations of both sides
  regSpec_t aExDest;
  logic     aExValid;
  regSpec_t bExDest;
  logic     bExValid;
  regSpec_t aMemDest;
  logic     aMemValid;
  regSpec_t bMemDest;
  logic     bMemValid;

  // ---------------------------------------------------------------------------
  // Destination decode where only the A side has the link register
  // ---------------------------------------------------------------------------
  destDecode #(.hasLink(1'b1)) aDecode (
    .phi1(phi1), .rst(rst), .stall(stall),
    .rtSpec(aRtSpec), .rdSpec(aRdSpec),
    .destIsRd(aDestIsRd), .destIsRt(aDestIsRt), .destIsLink(aDestIsLink),
    .kill(aKill), .except(except),
    .exDest(aExDest), .exValid(aExValid)
  );

  destDecode bDecode (
    .phi1(phi1), .rst(rst), .stall(stall),
    .rtSpec(bRtSpec), .rdSpec(bRdSpec),
    .destIsRd(bDestIsRd), .destIsRt(bDestIsRt), .destIsLink(1'b0),
    .kill(bKill), .except(except),
    .exDest(bExDest), .exValid(bExValid)
  );

  // ---------------------------------------------------------------------------
  // MEM and WB chains where loads only issue on B
  // ---------------------------------------------------------------------------
  destPipe aPipe (
    .phi1(phi1), .rst(rst), .stall(stall),
    .exDest(aExDest), .exValid(aExValid), .isLoad(1'b0),
    .ignore(aIgnore), .except(except),
    .memDest(aMemDest), .memValid(aMemValid), .memLoad(),
    .wbDest(aWbSpec), .wbValid(aWbValid), .wbLoad(),
    .memLatchEn(aMemLatchEn)
  );

  destPipe #(.hasLoad(1'b1)) bPipe (
    .phi1(phi1), .rst(rst), .stall(stall),
    .exDest(bExDest), .exValid(bExValid), .isLoad(bIsLoad),
    .ignore(bIgnore), .except(except),
    .memDest(bMemDest), .memValid(bMemValid), .memLoad(),
    .wbDest(bWbSpec), .wbValid(bWbValid), .wbLoad(bWbLoad),
    .memLatchEn(bMemLatchEn)
  );

  // ---------------------------------------------------------------------------
  // Bypass selects for the A side S and T operands
  // ---------------------------------------------------------------------------
  bypassSelect sSelect (
    .phi1(phi1), .rst(rst), .stall(stall), .srcSpec(aRsSpec),
    .aExDest(aExDest), .aExValid(aExValid), .bExDest(bExDest), .bExValid(bExValid),
    .aMemDest(aMemDest), .aMemValid(aMemValid),
    .bMemDest(bMemDest), .bMemValid(bMemValid),
    .bWbLoad(bWbLoad), .bWbValid(bWbValid), .aKill(aKill),
    .bypassSel(sBypassSel), .bypassLoad(sBypassLoad)
  );

  bypassSelect tSelect (
    .phi1(phi1), .rst(rst), .stall(stall), .srcSpec(aRtSpec),
    .aExDest(aExDest), .aExValid(aExValid), .bExDest(bExDest), .bExValid(bExValid),
    .aMemDest(aMemDest), .aMemValid(aMemValid),
    .bMemDest(bMemDest), .bMemValid(bMemValid),
    .bWbLoad(bWbLoad), .bWbValid(bWbValid), .aKill(aKill),
    .bypassSel(tBypassSel), .bypassLoad(tBypassLoad)
  );

endmodule

//--- bypassSelect.sv
// Source-to-destination compares, priority encoder, registered select, load bypass
`timescale 1ns/1ps
`include "bypass_defs.svh"

module bypassSelect (
  input  logic                  phi1,
  input  logic                  rst,
  input  logic                  stall,
  input  bypassPkg::regSpec_t   srcSpec,
  input  bypassPkg::regSpec_t   aExDest,
  input  logic                  aExValid,
  input  bypassPkg::regSpec_t   bExDest,
  input  logic                  bExValid,
  input  bypassPkg::regSpec_t   aMemDest,
  input  logic                  aMemValid,
  input  bypassPkg::regSpec_t   bMemDest,
  input  logic                  bMemValid,
  input  logic                  bWbLoad,
  input  logic                  bWbValid,
  input  logic                  aKill,
  output bypassPkg::bypassSel_t bypassSel,
  output logic                  bypassLoad
);

  import bypassPkg::*;

  localparam bypassSel_t selNoneOnly = bypassSel_t'(1) << `SEL_NONE;

  // Raw matches are not one-hot
  bypassSel_t hit;
  bypassSel_t selNext;

  // ---------------------------------------------------------------------------
  // Compares against the four in-flight destinations
  // ---------------------------------------------------------------------------
  // No-bypass line always hits and only wins when nothing newer does
  assign hit[`SEL_NONE] = 1'b1;
  assign hit[`SEL_AMEM] = aMemValid && (srcSpec == aMemDest);
  assign hit[`SEL_BMEM] = bMemValid && (srcSpec == bMemDest);
  assign hit[`SEL_AEX]  = aExValid && (srcSpec == aExDest);
  assign hit[`SEL_BEX]  = bExValid && (srcSpec == bExDest);

  // Newest first, B after A in program order so B wins
  // A hit survives only when no higher bit hits
  always_comb begin
    for (int i = 0; i < `SEL_W; i++) begin
      selNext[i] = hit[i] && ((hit >> (i + 1)) == '0);
    end
  end

  // Select drives the EX bypass mux in the next cycle
  always_ff @(posedge phi1) begin
    if (rst) begin
      bypassSel <= selNoneOnly;
    end else if (!stall) begin
      bypassSel <= selNext;
    end
  end

  // B MEM producer has moved on to WB by now
  // Load data comes off the fast path instead of the result bus
  assign bypassLoad = bypassSel[`SEL_BMEM] && bWbLoad && bWbValid && !aKill;

  selOneHot: assert property (
    @(posedge phi1) disable iff (rst)
    $onehot(bypassSel)
  );

endmodule

//--- destPipe.sv
// MEM and WB destination registers, valid qualification and MEM latch enable
`timescale 1ns/1ps

module destPipe #(
  parameter bit hasLoad = 1'b0
) (
  input  logic                phi1,
  input  logic                rst,
  input  logic                stall,
  input  bypassPkg::regSpec_t exDest,
  input  logic                exValid,
  input  logic                isLoad,
  input  logic                ignore,
  input  logic                except,
  output bypassPkg::regSpec_t memDest,
  output logic                memValid,
  output logic                memLoad,
  output bypassPkg::regSpec_t wbDest,
  output logic                wbValid,
  output logic                wbLoad,
  output logic                memLatchEn
);

  import bypassPkg::*;

  // Load flag only exists on the B side
  logic exLoad;
  logic memValidNext;
  logic wbValidNext;

  assign exLoad = hasLoad && isLoad;

  // Ignore drops the A or B copy of a dual-issued instruction
  assign memValidNext = exValid && !ignore;

  // An exception in MEM stops the write back
  assign wbValidNext = memValid && !except;

  // ---------------------------------------------------------------------------
  // EX to MEM
  // ---------------------------------------------------------------------------
  always_ff @(posedge phi1) begin
    if (rst) begin
      memDest  <= regSpec_t'(0);
      memValid <= 1'b0;
      memLoad  <= 1'b0;
    end else if (!stall) begin
      memDest  <= exDest;
      memValid <= memValidNext;
      memLoad  <= exLoad;
    end
  end

  // ---------------------------------------------------------------------------
  // MEM to WB
  // ---------------------------------------------------------------------------
  always_ff @(posedge phi1) begin
    if (rst) begin
      wbDest  <= regSpec_t'(0);
      wbValid <= 1'b0;
      wbLoad  <= 1'b0;
    end else if (!stall) begin
      wbDest  <= memDest;
      wbValid <= wbValidNext;
      wbLoad  <= memLoad;
    end
  end

  // Datapath MEM latches only toggle for a live result
  assign memLatchEn = memValid && !stall;

  // r0 qualification in EX has to hold all the way to WB
  validNonZero: assert property (
    @(posedge phi1) disable iff (rst)
    (memValid |-> memDest != '0) and (wbValid |-> wbDest != '0)
  );

endmodule

//--- destDecode.sv
// RF-to-EX specifier registers, destination choice and EX valid for one issue side
`timescale 1ns/1ps
`include "bypass_defs.svh"

module destDecode #(
  parameter bit hasLink = 1'b0
) (
  input  logic                phi1,
  input  logic                rst,
  input  logic                stall,
  input  bypassPkg::regSpec_t rtSpec,
  input  bypassPkg::regSpec_t rdSpec,
  input  logic                destIsRd,
  input  logic                destIsRt,
  input  logic                destIsLink,
  input  logic                kill,
  input  logic                except,
  output bypassPkg::regSpec_t exDest,
  output logic                exValid
);

  import bypassPkg::*;

  // RT and RD fields of the instruction now in EX
  regSpec_t rtSpecEx;
  regSpec_t rdSpecEx;

  // Link choice is tied off on the B side
  logic     linkSel;
  logic     noDest;
  logic     destIsZero;

  // ---------------------------------------------------------------------------
  // RF to EX
  // ---------------------------------------------------------------------------
  always_ff @(posedge phi1) begin
    if (rst) begin
      rtSpecEx <= '0;
      rdSpecEx <= '0;
    end else if (!stall) begin
      rtSpecEx <= rtSpec;
      rdSpecEx <= rdSpec;
    end
  end

  // ---------------------------------------------------------------------------
  // Destination choice in EX
  // ---------------------------------------------------------------------------
  assign linkSel = hasLink && destIsLink;

  // Selects are one-hot, so the chain order is not a real priority
  always_comb begin
    if (destIsRd) begin
      exDest = rdSpecEx;
    end else if (destIsRt) begin
      exDest = rtSpecEx;
    end else if (linkSel) begin
      exDest = regSpec_t'(`LINK_REG);
    end else begin
      exDest = '0;
    end
  end

  // No write back when nothing is selected
  assign noDest     = !(destIsRd || destIsRt || linkSel);
  // Writes to r0 are dropped, so r0 never bypasses
  assign destIsZero = (exDest == '0);

  // Kill, r0 and exception all drop the write
  assign exValid = !(noDest || kill || destIsZero || except);

  // Decoder hands over at most one destination select
  destSelOneHot: assert property (
    @(posedge phi1) disable iff (rst)
    $onehot0({destIsRd, destIsRt, destIsLink})
  );

endmodule

//--- bypassPkg.sv
// Register specifier and bypass select vector types
`include "bypass_defs.svh"

package bypassPkg;

  // Architectural register number of RS/RT/RD fields and destinations
  typedef logic [`SPEC_W-1:0] regSpec_t;

  // One-hot bypass mux control
  // Bit order follows the SEL_* positions
  typedef logic [`SEL_W-1:0] bypassSel_t;

endpackage

//--- bypass_defs.svh
// Specifier width, bypass select width, select bit positions, link register number
`ifndef BYPASS_DEFS_SVH
`define BYPASS_DEFS_SVH

// ---------------------------------------------------------------------------
// Widths
// ---------------------------------------------------------------------------

// Architectural register specifier for 32 registers
`define SPEC_W 5

// One-hot bypass mux control with one line per source
`define SEL_W 5

// ---------------------------------------------------------------------------
// Bypass select bit positions where the higher bit wins
// ---------------------------------------------------------------------------
`define SEL_NONE 0
`define SEL_AMEM 1
`define SEL_BMEM 2
`define SEL_AEX  3
`define SEL_BEX  4

// Written by jump-and-link on the A side
`define LINK_REG 31

`endif
